// File: common/csr_pkg.sv
package csr_pkg;

    parameter int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [11:0] csr_addr_t;

    // only user and machine mode are implemented
    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_m = 2'b11
    } priv_t;

    //////////////////////////////////////////////////////////////////////
    // csr addresses

    // user counter aliases
    localparam csr_addr_t csr_cycle         = 12'hC00;
    localparam csr_addr_t csr_instret       = 12'hC02;
    localparam csr_addr_t csr_cycleh        = 12'hC80;
    localparam csr_addr_t csr_instreth      = 12'hC82;

    // machine information
    localparam csr_addr_t csr_mvendorid     = 12'hF11;
    localparam csr_addr_t csr_marchid       = 12'hF12;
    localparam csr_addr_t csr_mimpid        = 12'hF13;
    localparam csr_addr_t csr_mhartid       = 12'hF14;
    localparam csr_addr_t csr_mconfigptr    = 12'hF15;

    // machine trap setup and handling
    localparam csr_addr_t csr_mstatus       = 12'h300;
    localparam csr_addr_t csr_misa          = 12'h301;
    localparam csr_addr_t csr_mie           = 12'h304;
    localparam csr_addr_t csr_mtvec         = 12'h305;
    localparam csr_addr_t csr_mstatush      = 12'h310;
    localparam csr_addr_t csr_mcountinhibit = 12'h320;
    localparam csr_addr_t csr_mscratch      = 12'h340;
    localparam csr_addr_t csr_mepc          = 12'h341;
    localparam csr_addr_t csr_mcause        = 12'h342;
    localparam csr_addr_t csr_mtval         = 12'h343;
    localparam csr_addr_t csr_mip           = 12'h344;

    // machine counters
    localparam csr_addr_t csr_mcycle        = 12'hB00;
    localparam csr_addr_t csr_minstret      = 12'hB02;
    localparam csr_addr_t csr_mcycleh       = 12'hB80;
    localparam csr_addr_t csr_minstreth     = 12'hB82;

    //////////////////////////////////////////////////////////////////////
    // constants

    // rv32i, mxl = 1
    localparam word_t misa_value = 32'h4000_0100;
    localparam word_t impl_id    = 32'h0000_0002;

    localparam logic [1:0] mtvec_mode_direct   = 2'd0;
    localparam logic [1:0] mtvec_mode_vectored = 2'd1;
    localparam int mtvec_align_bits = 7;

    localparam int mti_bit = 7;

    // mip / mie layout
    typedef struct packed {
        logic [15:0] platform;
        logic [3:0]  rsvd15_12;
        logic        mei;
        logic [2:0]  rsvd10_8;
        logic        mti;
        logic [2:0]  rsvd6_4;
        logic        msi;
        logic [2:0]  rsvd2_0;
    } irq_fields_t;

    typedef union packed {
        word_t       raw;
        irq_fields_t f;
    } irq_word_u;

endpackage

// File: source/csr_read_mux.sv
`timescale 1ns/1ns

module csr_read_mux #(
    parameter int hart_id = 0
) (
    input  logic                rst_n,
    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::priv_t      priv,
    input  csr_pkg::word_t      mstatus_rd,
    input  csr_pkg::word_t      mstatush_rd,
    input  csr_pkg::word_t      mtvec,
    input  csr_pkg::word_t      mepc,
    input  csr_pkg::word_t      mscratch,
    input  csr_pkg::word_t      mcause,
    input  csr_pkg::word_t      mtval,
    input  logic [63:0]         mcycle,
    input  logic [63:0]         minstret,
    input  csr_pkg::word_t      mcountinhibit,
    input  csr_pkg::irq_word_u  mip,
    input  csr_pkg::irq_word_u  mie,
    output csr_pkg::word_t      rd_data,
    output logic                rd_illegal
);

    logic           user_hit;
    logic           mach_hit;
    csr_pkg::word_t user_data;
    csr_pkg::word_t mach_data;

    // user level, readable in any mode
    always_comb begin
        user_hit  = 1'b1;
        user_data = '0;
        case (rd_addr)
            csr_pkg::csr_cycle:    user_data = mcycle[31:0];
            csr_pkg::csr_cycleh:   user_data = mcycle[63:32];
            csr_pkg::csr_instret:  user_data = minstret[31:0];
            csr_pkg::csr_instreth: user_data = minstret[63:32];
            default:               user_hit  = 1'b0;
        endcase
    end

    // machine level
    always_comb begin
        mach_hit  = 1'b1;
        mach_data = '0;
        case (rd_addr)
            csr_pkg::csr_misa:          mach_data = csr_pkg::misa_value;
            csr_pkg::csr_mvendorid:     mach_data = '0;
            csr_pkg::csr_marchid:       mach_data = '0;
            csr_pkg::csr_mimpid:        mach_data = csr_pkg::impl_id;
            csr_pkg::csr_mhartid:       mach_data = csr_pkg::word_t'(hart_id);
            csr_pkg::csr_mconfigptr:    mach_data = '0;
            csr_pkg::csr_mstatus:       mach_data = mstatus_rd;
            csr_pkg::csr_mstatush:      mach_data = mstatush_rd;
            csr_pkg::csr_mtvec:         mach_data = mtvec;
            csr_pkg::csr_mip:           mach_data = mip.raw;
            csr_pkg::csr_mie:           mach_data = mie.raw;
            csr_pkg::csr_mcycle:        mach_data = mcycle[31:0];
            csr_pkg::csr_mcycleh:       mach_data = mcycle[63:32];
            csr_pkg::csr_minstret:      mach_data = minstret[31:0];
            csr_pkg::csr_minstreth:     mach_data = minstret[63:32];
            csr_pkg::csr_mcountinhibit: mach_data = mcountinhibit;
            csr_pkg::csr_mscratch:      mach_data = mscratch;
            csr_pkg::csr_mepc:          mach_data = mepc;
            csr_pkg::csr_mcause:        mach_data = mcause;
            csr_pkg::csr_mtval:         mach_data = mtval;
            default:                    mach_hit  = 1'b0;
        endcase
    end

    always_comb begin
        if (!rst_n) begin
            rd_data    = '0;
            rd_illegal = 1'b0;
        end else if (user_hit) begin
            rd_data    = user_data;
            rd_illegal = 1'b0;
        end else if (mach_hit && priv == csr_pkg::priv_m) begin
            rd_data    = mach_data;
            rd_illegal = 1'b0;
        end else begin
            // unknown address, or machine csr from user mode
            rd_data    = '0;
            rd_illegal = 1'b1;
        end
    end

endmodule

// File: source/csr_counters.sv
`timescale 1ns/1ns

module csr_counters (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_commit,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::word_t      wr_data,
    input  logic                stall_exec,
    input  logic                bubble_exec,
    output logic [63:0]         mcycle,
    output logic [63:0]         minstret,
    output csr_pkg::word_t      mcountinhibit
);

    logic retire;

    // a half write replaces the increment for that cycle
    function automatic logic [63:0] next_count(
        input logic [63:0]    cur,
        input logic           wr_lo,
        input logic           wr_hi,
        input logic           inc,
        input csr_pkg::word_t data
    );
        if (wr_lo) begin
            return {cur[63:32], data};
        end else if (wr_hi) begin
            return {data, cur[31:0]};
        end else if (inc) begin
            return cur + 64'd1;
        end
        return cur;
    endfunction

    assign retire = !stall_exec && !bubble_exec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle        <= '0;
            minstret      <= '0;
            mcountinhibit <= '0;
        end else begin
            mcycle <= next_count(mcycle,
                wr_commit && wr_addr == csr_pkg::csr_mcycle,
                wr_commit && wr_addr == csr_pkg::csr_mcycleh,
                !mcountinhibit[0], wr_data);
            minstret <= next_count(minstret,
                wr_commit && wr_addr == csr_pkg::csr_minstret,
                wr_commit && wr_addr == csr_pkg::csr_minstreth,
                retire && !mcountinhibit[2], wr_data);
            // only CY and IR are implemented
            if (wr_commit && wr_addr == csr_pkg::csr_mcountinhibit) begin
                mcountinhibit <= wr_data & 32'h0000_0005;
            end
        end
    end

endmodule

// File: source/csr_interrupts.sv
`timescale 1ns/1ns

module csr_interrupts (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_commit,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::word_t      wr_data,
    input  logic                mtime_interrupt,
    input  csr_pkg::word_t      int_sources,
    input  csr_pkg::priv_t      priv,
    input  logic                mstatus_mie,
    output csr_pkg::irq_word_u  mip,
    output csr_pkg::irq_word_u  mie,
    output csr_pkg::word_t      interrupts
);

    logic [15:0] pend_platform;
    logic [15:0] en_platform;
    logic        en_mti;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_platform <= '0;
            en_platform   <= '0;
            en_mti        <= 1'b0;
        end else begin
            // sticky pending, a mip write can only clear idle sources
            if (wr_commit && wr_addr == csr_pkg::csr_mip) begin
                pend_platform <= wr_data[31:16] | int_sources[31:16];
            end else begin
                pend_platform <= pend_platform | int_sources[31:16];
            end
            if (wr_commit && wr_addr == csr_pkg::csr_mie) begin
                en_platform <= wr_data[31:16];
                en_mti      <= wr_data[csr_pkg::mti_bit];
            end
        end
    end

    always_comb begin
        mip            = '0;
        mip.f.platform = pend_platform;
        mip.f.mti      = mtime_interrupt;
        mie            = '0;
        mie.f.platform = en_platform;
        mie.f.mti      = en_mti;
    end

    // machine mode honours mstatus.MIE, user mode is always open
    assign interrupts = (priv == csr_pkg::priv_m && !mstatus_mie) ? '0
                                                                  : (mip.raw & mie.raw);

endmodule

// File: machine_status/machine_status.sv
`timescale 1ns/1ns

module machine_status (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  csr_pkg::word_t      wr_data,
    input  logic                stall_exec,
    input  logic                bubble_exec,
    input  logic                trap_insert,
    input  logic                trap_is_mret,
    input  csr_pkg::word_t      trap_epc,
    input  csr_pkg::word_t      trap_cause,
    input  csr_pkg::word_t      trap_val,
    output csr_pkg::priv_t      priv,
    output logic                wr_commit,
    output csr_pkg::word_t      mstatus_rd,
    output csr_pkg::word_t      mstatush_rd,
    output logic                mstatus_mie,
    output csr_pkg::word_t      mtvec,
    output csr_pkg::word_t      mepc,
    output csr_pkg::word_t      mscratch,
    output csr_pkg::word_t      mcause,
    output csr_pkg::word_t      mtval,
    output logic                endianness
);

    localparam int align = csr_pkg::mtvec_align_bits;

    // writable mstatus fields
    logic           mprv;
    csr_pkg::priv_t mpp;
    logic           mpie;
    logic           ube;
    logic           status_mie;
    logic           mbe;

    // execute stage must hold a real instruction, machine mode only
    assign wr_commit = wr_en && !stall_exec && !bubble_exec && priv == csr_pkg::priv_m;

    //////////////////////////////////////////////////////////////////////
    // privilege, mstatus, mtvec, mepc

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv       <= csr_pkg::priv_m;
            mprv       <= 1'b0;
            mpp        <= csr_pkg::priv_u;
            mpie       <= 1'b1;
            ube        <= 1'b0;
            status_mie <= 1'b1;
            mbe        <= 1'b0;
            mtvec      <= '0;
            mepc       <= '0;
        end else begin
            if (wr_commit) begin
                case (wr_addr)
                    csr_pkg::csr_mstatus: begin
                        mprv       <= wr_data[17];
                        // only U and M exist
                        mpp        <= (wr_data[12:11] == csr_pkg::priv_m) ? csr_pkg::priv_m
                                                                          : csr_pkg::priv_u;
                        mpie       <= wr_data[7];
                        ube        <= wr_data[6];
                        status_mie <= wr_data[3];
                    end
                    csr_pkg::csr_mstatush: mbe <= wr_data[5];
                    csr_pkg::csr_mtvec: begin
                        if (wr_data[1:0] == csr_pkg::mtvec_mode_vectored) begin
                            mtvec <= {wr_data[csr_pkg::xlen-1:align], {(align-2){1'b0}},
                                      csr_pkg::mtvec_mode_vectored};
                        end else begin
                            // reserved modes fall back to direct
                            mtvec <= {wr_data[csr_pkg::xlen-1:2], csr_pkg::mtvec_mode_direct};
                        end
                    end
                    csr_pkg::csr_mepc: mepc <= {wr_data[csr_pkg::xlen-1:2], 2'b00};
                    default: ;
                endcase
            end

            // trap wins over a csr write in the same cycle
            if (trap_insert) begin
                if (trap_is_mret) begin
                    priv       <= mpp;
                    status_mie <= mpie;
                    mpie       <= 1'b1;
                    mpp        <= csr_pkg::priv_u;
                    if (mpp != csr_pkg::priv_m) begin
                        mprv <= 1'b0;
                    end
                end else begin
                    priv       <= csr_pkg::priv_m;
                    mpie       <= status_mie;
                    status_mie <= 1'b0;
                    mpp        <= priv;
                    mepc       <= trap_epc;
                end
            end
        end
    end

    // scratch and trap info
    always_ff @(posedge clk) begin
        if (wr_commit && wr_addr == csr_pkg::csr_mscratch) begin
            mscratch <= wr_data;
        end
        if (trap_insert && !trap_is_mret) begin
            mcause <= trap_cause;
            mtval  <= trap_val;
        end else if (wr_commit) begin
            if (wr_addr == csr_pkg::csr_mcause) begin
                mcause <= wr_data;
            end
            if (wr_addr == csr_pkg::csr_mtval) begin
                mtval <= wr_data;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read views

    // sie and spie read as 1, other supervisor fields 0
    assign mstatus_rd = {14'b0, mprv, 4'b0, mpp, 3'b0, mpie, ube, 1'b1,
                         1'b0, status_mie, 1'b0, 1'b1, 1'b0};
    assign mstatush_rd = {26'b0, mbe, 5'b0};
    assign mstatus_mie = status_mie;

    //////////////////////////////////////////////////////////////////////
    // effective data endianness

    always_comb begin
        if (priv == csr_pkg::priv_m) begin
            if (mprv) begin
                // loads and stores use the MPP mode
                endianness = (mpp == csr_pkg::priv_m) ? mbe : ube;
            end else begin
                endianness = mbe;
            end
        end else begin
            endianness = ube;
        end
    end

endmodule

// File: source/csr_top.sv
`timescale 1ns/1ns

module csr_top #(
    parameter int hart_id = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::csr_addr_t  wr_addr,
    input  logic                wr_en,
    input  csr_pkg::word_t      wr_data,
    input  logic                stall_exec,
    input  logic                bubble_exec,
    input  logic                trap_insert,
    input  logic                trap_is_mret,
    input  csr_pkg::word_t      trap_epc,
    input  csr_pkg::word_t      trap_cause,
    input  csr_pkg::word_t      trap_val,
    input  logic                mtime_interrupt,
    input  csr_pkg::word_t      int_sources,
    output csr_pkg::word_t      rd_data,
    output logic                rd_illegal,
    output csr_pkg::word_t      mepc,
    output csr_pkg::word_t      mtvec,
    output csr_pkg::word_t      interrupts,
    output logic                endianness
);

    csr_pkg::priv_t     priv;
    logic               wr_commit;
    logic               mstatus_mie;
    csr_pkg::word_t     mstatus_rd;
    csr_pkg::word_t     mstatush_rd;
    csr_pkg::word_t     mscratch;
    csr_pkg::word_t     mcause;
    csr_pkg::word_t     mtval;
    logic [63:0]        mcycle;
    logic [63:0]        minstret;
    csr_pkg::word_t     mcountinhibit;
    csr_pkg::irq_word_u mip;
    csr_pkg::irq_word_u mie;

    machine_status u_status (
        .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .stall_exec, .bubble_exec,
        .trap_insert, .trap_is_mret, .trap_epc, .trap_cause, .trap_val,
        .priv, .wr_commit, .mstatus_rd, .mstatush_rd, .mstatus_mie,
        .mtvec, .mepc, .mscratch, .mcause, .mtval, .endianness
    );

    csr_counters u_counters (
        .clk, .rst_n, .wr_commit, .wr_addr, .wr_data, .stall_exec, .bubble_exec,
        .mcycle, .minstret, .mcountinhibit
    );

    csr_interrupts u_interrupts (
        .clk, .rst_n, .wr_commit, .wr_addr, .wr_data, .mtime_interrupt,
        .int_sources, .priv, .mstatus_mie, .mip, .mie, .interrupts
    );

    csr_read_mux #(.hart_id(hart_id)) u_read_mux (
        .rst_n, .rd_addr, .priv, .mstatus_rd, .mstatush_rd,
        .mtvec, .mepc, .mscratch, .mcause, .mtval,
        .mcycle, .minstret, .mcountinhibit, .mip, .mie,
        .rd_data, .rd_illegal
    );

endmodule

// File: verification/csr_tb_model.svh
`ifndef csr_tb_model_svh
`define csr_tb_model_svh

// constant machine registers, everything else unlisted reads 0
function automatic logic [31:0] const_csr_value(input logic [11:0] addr, input int hart);
    case (addr)
        csr_pkg::csr_misa:   return 32'h4000_0100;
        csr_pkg::csr_mimpid: return 32'd2;
        csr_pkg::csr_mhartid: return 32'(hart);
        default:             return 32'd0;
    endcase
endfunction

// sie and spie always read as 1
function automatic logic [31:0] mstatus_value(input logic mprv, input logic [1:0] mpp,
        input logic mpie, input logic ube, input logic mie);
    logic [31:0] v;
    v        = 32'h0000_0022;
    v[17]    = mprv;
    v[12:11] = mpp;
    v[7]     = mpie;
    v[6]     = ube;
    v[3]     = mie;
    return v;
endfunction

// vectored base aligned to 128 bytes, reserved modes become direct
function automatic logic [31:0] mtvec_legal(input logic [31:0] w);
    if (w[1:0] == 2'd1) begin
        return {w[31:7], 5'b0, 2'b01};
    end
    return {w[31:2], 2'b00};
endfunction

function automatic logic [31:0] masked_irq(input logic [31:0] pend, input logic [31:0] en,
        input logic in_m, input logic mie);
    if (in_m && !mie) begin
        return 32'd0;
    end
    return pend & en;
endfunction

function automatic logic data_endian(input logic in_m, input logic mprv, input logic mpp_m,
        input logic mbe, input logic ube);
    if (!in_m) begin
        return ube;
    end
    if (mprv) begin
        return mpp_m ? mbe : ube;
    end
    return mbe;
endfunction

`endif

// File: verification/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;

    localparam int hart_id     = 3;
    localparam int num_tests   = 6;
    localparam int test_cycles = 200;

    logic               clk;
    logic               rst_n;
    csr_pkg::csr_addr_t rd_addr;
    csr_pkg::csr_addr_t wr_addr;
    logic               wr_en;
    csr_pkg::word_t     wr_data;
    logic               stall_exec;
    logic               bubble_exec;
    logic               trap_insert;
    logic               trap_is_mret;
    csr_pkg::word_t     trap_epc;
    csr_pkg::word_t     trap_cause;
    csr_pkg::word_t     trap_val;
    logic               mtime_interrupt;
    csr_pkg::word_t     int_sources;
    csr_pkg::word_t     rd_data;
    logic               rd_illegal;
    csr_pkg::word_t     mepc;
    csr_pkg::word_t     mtvec;
    csr_pkg::word_t     interrupts;
    logic               endianness;

    // queued read expectations in issue order
    csr_pkg::csr_addr_t exp_addr_q[$];
    logic [31:0]        exp_data_q[$];
    logic               exp_ill_q[$];

    int          errors;
    int          checks;
    int          test_errors;
    int          n_inc;
    logic [31:0] rnd;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] scratch;
    logic [31:0] tvec_exp;
    logic [31:0] pend;
    logic [31:0] en;
    logic [3:0]  combo;
    logic        ill;
    logic        st;
    logic        bb;

    `include "csr_tb_model.svh"

    csr_top #(.hart_id(hart_id)) dut (.*);

    always #5 clk = ~clk;

    initial begin
        #(num_tests * test_cycles * 10);
        $display("timeout, tests still running after %0d ns", num_tests * test_cycles * 10);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // checking

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // reads settle half a cycle after the address is driven
    always @(negedge clk) begin
        if (exp_addr_q.size() > 0) begin
            check_value($sformatf("rd_data[%h]", exp_addr_q[0]), rd_data, exp_data_q[0]);
            check_value($sformatf("rd_illegal[%h]", exp_addr_q[0]), rd_illegal, exp_ill_q[0]);
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_ill_q.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks start and end just after a rising edge

    task automatic write_csr(input csr_pkg::csr_addr_t addr, input logic [31:0] data);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic expect_read(input csr_pkg::csr_addr_t addr, input logic [31:0] data,
            input logic illegal);
        rd_addr <= addr;
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
        exp_ill_q.push_back(illegal);
        @(posedge clk);
    endtask

    task automatic sample_read(input csr_pkg::csr_addr_t addr, output logic [31:0] data,
            output logic illegal);
        rd_addr <= addr;
        @(negedge clk);
        data    = rd_data;
        illegal = rd_illegal;
        @(posedge clk);
    endtask

    task automatic expect_outputs(input logic [31:0] irq, input logic endian);
        @(negedge clk);
        check_value("interrupts", interrupts, irq);
        check_value("endianness", endianness, endian);
        @(posedge clk);
    endtask

    task automatic expect_vectors(input logic [31:0] epc, input logic [31:0] tvec);
        @(negedge clk);
        check_value("mepc", mepc, epc);
        check_value("mtvec", mtvec, tvec);
        @(posedge clk);
    endtask

    task automatic take_trap(input logic is_mret, input logic [31:0] epc,
            input logic [31:0] cause, input logic [31:0] val);
        trap_insert  <= 1'b1;
        trap_is_mret <= is_mret;
        trap_epc     <= epc;
        trap_cause   <= cause;
        trap_val     <= val;
        @(posedge clk);
        trap_insert <= 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    initial begin
        void'($urandom(4));
        clk             = 1'b0;
        rst_n           = 1'b0;
        rd_addr         = '0;
        wr_addr         = '0;
        wr_en           = 1'b0;
        wr_data         = '0;
        stall_exec      = 1'b0;
        bubble_exec     = 1'b0;
        trap_insert     = 1'b0;
        trap_is_mret    = 1'b0;
        trap_epc        = '0;
        trap_cause      = '0;
        trap_val        = '0;
        mtime_interrupt = 1'b0;
        int_sources     = '0;
        errors          = 0;
        checks          = 0;
        test_errors     = 0;
        repeat (3) @(posedge clk);
        // reads stay quiet while reset is held
        expect_read(csr_pkg::csr_misa, 32'd0, 1'b0);
        rst_n <= 1'b1;
        @(posedge clk);

        // reset values and constants
        expect_read(csr_pkg::csr_misa, const_csr_value(csr_pkg::csr_misa, hart_id), 1'b0);
        expect_read(csr_pkg::csr_mhartid, const_csr_value(csr_pkg::csr_mhartid, hart_id), 1'b0);
        expect_read(csr_pkg::csr_mimpid, const_csr_value(csr_pkg::csr_mimpid, hart_id), 1'b0);
        expect_read(csr_pkg::csr_mvendorid, const_csr_value(csr_pkg::csr_mvendorid, hart_id),
                    1'b0);
        expect_read(csr_pkg::csr_mstatus, mstatus_value(1'b0, 2'b00, 1'b1, 1'b0, 1'b1), 1'b0);
        expect_read(csr_pkg::csr_mtvec, 32'd0, 1'b0);
        expect_read(csr_pkg::csr_mie, 32'd0, 1'b0);
        expect_read(12'h7FF, 32'd0, 1'b1);
        expect_outputs(32'd0, 1'b0);
        expect_vectors(32'd0, 32'd0);
        finish_test(1, "reset");

        // plain writes and legalization
        scratch = $urandom;
        write_csr(csr_pkg::csr_mscratch, scratch);
        expect_read(csr_pkg::csr_mscratch, scratch, 1'b0);
        rnd = $urandom;
        write_csr(csr_pkg::csr_mcause, rnd);
        expect_read(csr_pkg::csr_mcause, rnd, 1'b0);
        rnd = $urandom;
        write_csr(csr_pkg::csr_mtval, rnd);
        expect_read(csr_pkg::csr_mtval, rnd, 1'b0);
        rnd = $urandom;
        write_csr(csr_pkg::csr_mepc, rnd);
        v1 = {rnd[31:2], 2'b00};
        expect_read(csr_pkg::csr_mepc, v1, 1'b0);
        for (int m = 1; m < 4; m++) begin
            rnd      = $urandom;
            rnd[1:0] = m[1:0];
            tvec_exp = mtvec_legal(rnd);
            write_csr(csr_pkg::csr_mtvec, rnd);
            expect_read(csr_pkg::csr_mtvec, tvec_exp, 1'b0);
            expect_vectors(v1, tvec_exp);
        end
        // MPP=2 is not a mode here
        write_csr(csr_pkg::csr_mstatus, 32'h0000_1088);
        expect_read(csr_pkg::csr_mstatus, mstatus_value(1'b0, 2'b00, 1'b1, 1'b0, 1'b1), 1'b0);
        stall_exec <= 1'b1;
        write_csr(csr_pkg::csr_mscratch, ~scratch);
        stall_exec <= 1'b0;
        expect_read(csr_pkg::csr_mscratch, scratch, 1'b0);
        bubble_exec <= 1'b1;
        write_csr(csr_pkg::csr_mscratch, ~scratch);
        bubble_exec <= 1'b0;
        expect_read(csr_pkg::csr_mscratch, scratch, 1'b0);
        finish_test(2, "writes");

        // counters
        sample_read(csr_pkg::csr_mcycle, v0, ill);
        repeat (9) @(posedge clk);
        expect_read(csr_pkg::csr_mcycle, v0 + 32'd10, 1'b0);
        sample_read(csr_pkg::csr_minstret, v0, ill);
        n_inc = 1;
        for (int i = 0; i < 8; i++) begin
            st = $urandom % 2;
            bb = ($urandom % 3) == 0;
            stall_exec  <= st;
            bubble_exec <= bb;
            n_inc += (!st && !bb);
            @(posedge clk);
        end
        stall_exec  <= 1'b0;
        bubble_exec <= 1'b0;
        expect_read(csr_pkg::csr_minstret, v0 + 32'(n_inc), 1'b0);
        write_csr(csr_pkg::csr_mcountinhibit, 32'hFFFF_FFFF);
        expect_read(csr_pkg::csr_mcountinhibit, 32'h0000_0005, 1'b0);
        sample_read(csr_pkg::csr_mcycle, v0, ill);
        sample_read(csr_pkg::csr_minstret, v1, ill);
        repeat (5) @(posedge clk);
        expect_read(csr_pkg::csr_mcycle, v0, 1'b0);
        expect_read(csr_pkg::csr_minstret, v1, 1'b0);
        rnd = $urandom;
        write_csr(csr_pkg::csr_mcycleh, rnd);
        expect_read(csr_pkg::csr_mcycleh, rnd, 1'b0);
        expect_read(csr_pkg::csr_cycleh, rnd, 1'b0);
        write_csr(csr_pkg::csr_mcountinhibit, 32'd0);
        finish_test(3, "counters");

        // trap entry from machine mode
        rnd = $urandom & 32'hFFFF_FFFC;
        v0  = $urandom;
        take_trap(1'b0, rnd, 32'd2, v0);
        expect_read(csr_pkg::csr_mepc, rnd, 1'b0);
        expect_read(csr_pkg::csr_mcause, 32'd2, 1'b0);
        expect_read(csr_pkg::csr_mtval, v0, 1'b0);
        expect_read(csr_pkg::csr_mstatus, mstatus_value(1'b0, 2'b11, 1'b1, 1'b0, 1'b0), 1'b0);
        expect_vectors(rnd, tvec_exp);
        // mret with MPP=U drops to user mode
        write_csr(csr_pkg::csr_mstatus, 32'h0000_0080);
        take_trap(1'b1, 32'd0, 32'd0, 32'd0);
        expect_read(csr_pkg::csr_mstatus, 32'd0, 1'b1);
        sample_read(csr_pkg::csr_cycle, v1, ill);
        check_value("rd_illegal[c00]", ill, 1'b0);
        write_csr(csr_pkg::csr_mscratch, ~scratch);
        take_trap(1'b0, 32'h0000_0100, 32'd8, 32'd0);
        expect_read(csr_pkg::csr_mstatus, mstatus_value(1'b0, 2'b00, 1'b1, 1'b0, 1'b0), 1'b0);
        expect_read(csr_pkg::csr_mscratch, scratch, 1'b0);
        expect_read(csr_pkg::csr_mcause, 32'd8, 1'b0);
        finish_test(4, "trap");

        // interrupts
        write_csr(csr_pkg::csr_mstatus, 32'h0000_0008);
        int_sources <= 32'h0010_0000;
        @(posedge clk);
        int_sources <= '0;
        repeat (2) @(posedge clk);
        pend = 32'h0010_0000;
        expect_read(csr_pkg::csr_mip, pend, 1'b0);
        en = pend;
        write_csr(csr_pkg::csr_mie, en);
        expect_outputs(masked_irq(pend, en, 1'b1, 1'b1), 1'b0);
        write_csr(csr_pkg::csr_mstatus, 32'd0);
        expect_outputs(masked_irq(pend, en, 1'b1, 1'b0), 1'b0);
        mtime_interrupt <= 1'b1;
        en = en | (32'd1 << 7);
        write_csr(csr_pkg::csr_mie, en);
        write_csr(csr_pkg::csr_mstatus, 32'h0000_0008);
        pend = pend | (32'd1 << 7);
        expect_read(csr_pkg::csr_mip, pend, 1'b0);
        expect_outputs(masked_irq(pend, en, 1'b1, 1'b1), 1'b0);
        // bit 21 still active while bit 20 is idle
        int_sources <= 32'h0020_0000;
        write_csr(csr_pkg::csr_mip, 32'd0);
        expect_read(csr_pkg::csr_mip, 32'h0020_0080, 1'b0);
        int_sources     <= '0;
        mtime_interrupt <= 1'b0;
        pend = 32'h0020_0000;
        en   = 32'h0020_0000;
        write_csr(csr_pkg::csr_mie, en);
        write_csr(csr_pkg::csr_mstatus, 32'd0);
        take_trap(1'b1, 32'd0, 32'd0, 32'd0);
        expect_outputs(masked_irq(pend, en, 1'b0, 1'b0), 1'b0);
        take_trap(1'b0, 32'd0, 32'd0, 32'd0);
        finish_test(5, "interrupts");

        // endianness in machine mode with every MBE/UBE/MPRV/MPP mix
        for (int i = 0; i < 16; i++) begin
            combo = 4'(i);
            write_csr(csr_pkg::csr_mstatush, 32'(combo[0]) << 5);
            write_csr(csr_pkg::csr_mstatus, (32'(combo[2]) << 17) | (32'(combo[1]) << 6)
                      | (combo[3] ? 32'h0000_1800 : 32'h0));
            expect_outputs(masked_irq(pend, en, 1'b1, 1'b0),
                           data_endian(1'b1, combo[2], combo[3], combo[0], combo[1]));
        end
        // user mode where mret must also drop MPRV
        for (int i = 0; i < 4; i++) begin
            combo = 4'(i);
            write_csr(csr_pkg::csr_mstatush, 32'(combo[0]) << 5);
            write_csr(csr_pkg::csr_mstatus, 32'h0002_0000 | (32'(combo[1]) << 6));
            take_trap(1'b1, 32'd0, 32'd0, 32'd0);
            expect_outputs(masked_irq(pend, en, 1'b0, 1'b0),
                           data_endian(1'b0, 1'b0, 1'b0, combo[0], combo[1]));
            take_trap(1'b0, 32'd0, 32'd0, 32'd0);
            expect_read(csr_pkg::csr_mstatus,
                        mstatus_value(1'b0, 2'b00, 1'b0, combo[1], 1'b0), 1'b0);
        end
        finish_test(6, "endianness");

        $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
common/csr_pkg.sv
source/csr_read_mux.sv
source/csr_counters.sv
source/csr_interrupts.sv
machine_status/machine_status.sv
source/csr_top.sv
verification/csr_tb.sv
